/* testbench/mem_patterns.txt */
# op addr width data rd exp abort  (addr, data, rd and exp in hex; width and abort in decimal)
# width 0 byte, 1 half, 2 word; for cache it is the cache_op and exp holds i_inval,d_inval,d_flush
store 00000010 2 deadbeef 0 00000000 0
load 00000010 2 00000000 3 deadbeef 0
store 000003fc 2 a5a55a5a 0 00000000 0
load 000003fc 2 00000000 e a5a55a5a 0
store 00000000 2 0badf00d 0 00000000 0
store 00000024 2 01234567 0 00000000 0
store 00000024 0 123456aa 0 00000000 0
store 00000025 0 5a5a5abb 0 00000000 0
store 00000026 0 000000cc 0 00000000 0
store 00000027 0 ffffffdd 0 00000000 0
load 00000024 2 00000000 5 ddccbbaa 0
load 00000024 0 00000000 6 000000aa 0
load 00000025 0 00000000 7 000000bb 0
load 00000026 0 00000000 8 000000cc 0
load 00000027 0 00000000 9 000000dd 0
store 00000030 2 00000000 0 00000000 0
store 00000030 1 ffffbeef 0 00000000 0
store 00000032 1 1234cafe 0 00000000 0
load 00000030 2 00000000 a cafebeef 0
load 00000030 1 00000000 b 0000beef 0
load 00000032 1 00000000 c 0000cafe 0
load 00000031 0 00000000 d 000000be 0
alu 00000000 0 12345678 d 12345678 0
alu 00000000 0 87654321 1 87654321 0
load 00000400 2 00000000 2 00000000 1
store 00000800 2 11111111 0 00000000 1
load 00000000 2 00000000 f 0badf00d 0
cache 00000000 0 00000135 0 00000004 0
cache 00000000 1 000000a7 0 00000002 0
cache 00000000 2 000001ff 0 00000001 0
dbg_write 00000040 2 13579bdf 0 00000000 0
dbg_read 00000040 2 00000000 0 13579bdf 0
dbg_write 00000042 1 00002468 0 00000000 0
dbg_read 00000043 0 00000000 0 00000024 0
load 00000040 2 00000000 4 24689bdf 0
dbg_read 00000500 2 00000000 0 00000000 1
alu 00000000 0 00c0ffee 7 00c0ffee 0

/* project.f */
hw/mem_stage_pkg.sv
hw/mem_lane_align.sv
hw/mem_cache_maint.sv
hw/mem_writeback.sv
hw/data_ram.sv
hw/mem_stage.sv
testbench/tb_mem_stage.sv

/* Bender.yml */
package:
  name: mem_stage

sources:
  - hw/mem_stage_pkg.sv
  - hw/mem_lane_align.sv
  - hw/mem_cache_maint.sv
  - hw/mem_writeback.sv
  - hw/data_ram.sv
  - hw/mem_stage.sv
  - target: test
    files:
      - testbench/tb_mem_stage.sv

/* testbench/tb_mem_stage.sv */
`timescale 1ns/1ns

module tb_mem_stage;
	import mem_stage_pkg::*;

	localparam int TIMEOUT_CYCLES = 20;
	localparam string PATTERN_FILE = "testbench/mem_patterns.txt";

	logic                       clk;
	logic                       rst;
	mem_req_t                   mem_req;
	logic [31:0]                wr_val;
	logic                       update_rd;
	logic [3:0]                 rd_sel;
	logic                       cache_instr;
	cache_op_e                  cache_op;
	logic                       i_cacheop_complete;
	logic                       d_cacheop_complete;
	logic                       dbg_en;
	dbg_req_t                   dbg_req;
	wb_t                        wb;
	logic                       complete;
	logic                       data_abort;
	logic                       busy;
	logic [31:0]                dbg_rd_val;
	logic                       dbg_compl;
	logic                       i_inval;
	logic                       d_inval;
	logic                       d_flush;
	logic [ICACHE_IDX_BITS-1:0] i_idx;
	logic [DCACHE_IDX_BITS-1:0] d_idx;

	logic [31:0] ram_model [2**RAM_ADDR_BITS]; // Expected RAM contents, word indexed
	int          test_errors;
	int          pass_count;
	int          fail_count;

	mem_stage u_dut (.*);

	always #4 clk = ~clk;

	task automatic check_wb(input string name, input wb_t exp, input wb_t act);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s expected %b/%h/%h, got %b/%h/%h", $time, name,
				exp.update_rd, exp.rd_sel, exp.val, act.update_rd, act.rd_sel, act.val);
			test_errors++;
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
			test_errors++;
		end
	endtask

	// Outputs are sampled at the falling edge, before new inputs are driven
	task automatic wait_complete(output int cycles);
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!complete && cycles < TIMEOUT_CYCLES);
		if (!complete) begin
			$display("Timeout at %0t: complete did not rise within %0d cycles",
				$time, TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	endtask

	function automatic logic [31:0] model_read(input logic [31:0] addr, input mem_width_e width);
		logic [31:0] word;
		word = ram_model[addr[RAM_ADDR_BITS+1:2]];
		case (width)
			width_byte: return {24'b0, word[addr[1:0]*8 +: 8]};
			width_half: return addr[1] ? {16'b0, word[31:16]} : {16'b0, word[15:0]};
			default: return word;
		endcase
	endfunction

	task automatic model_write(input logic [31:0] addr, input mem_width_e width,
			input logic [31:0] data);
		logic [RAM_ADDR_BITS-1:0] idx;
		idx = addr[RAM_ADDR_BITS+1:2];
		case (width)
			width_byte: ram_model[idx][addr[1:0]*8 +: 8] = data[7:0];
			width_half: begin
				if (addr[1])
					ram_model[idx][31:16] = data[15:0];
				else
					ram_model[idx][15:0] = data[15:0];
			end
			default: ram_model[idx] = data;
		endcase
	endtask

	// One pipeline or debug access, held until complete
	task automatic run_access(input bit is_dbg, input bit is_write, input logic [31:0] addr,
			input mem_width_e width, input logic [31:0] data, input logic [3:0] rd,
			input logic [31:0] exp, input logic abort);
		int          cycles;
		wb_t         exp_wb;
		logic [31:0] model_val;
		if (is_dbg) begin
			dbg_en = 1'b1;
			dbg_req = '{access: 1'b1, wr_en: is_write, addr: addr, width: width, wr_val: data};
		end else begin
			mem_req = '{load: !is_write, store: is_write, addr: addr, mdr: data, width: width,
				rd_sel: rd};
		end
		if (abort !== (addr >= (32'd4 << RAM_ADDR_BITS))) begin
			$display("Pattern abort flag %b does not match the RAM size for address %h",
				abort, addr);
			test_errors++;
		end
		wait_complete(cycles);
		check_bit("data_abort", abort, data_abort);
		check_bit("busy", !is_dbg, busy);
		check_bit("dbg_compl", is_dbg, dbg_compl);
		if (!is_write && !abort) begin
			model_val = model_read(addr, width);
			if (model_val !== exp) begin
				$display("Pattern expects %h at %h but the RAM model holds %h",
					exp, addr, model_val);
				test_errors++;
			end
			if (is_dbg)
				check_word("dbg_rd_val", exp, dbg_rd_val);
		end
		if (is_write && !abort)
			model_write(addr, width, data);
		mem_req.load = 1'b0; // Address and width stay put while the load data is captured
		mem_req.store = 1'b0;
		dbg_req.access = 1'b0;
		@(negedge clk);
		if (!is_dbg && !is_write && !abort) begin
			exp_wb = '{update_rd: 1'b1, rd_sel: rd, val: exp};
			check_wb("wb", exp_wb, wb);
			check_word("load latency", 32'd2, 32'(cycles + 1));
		end else begin
			check_bit("wb.update_rd", 1'b0, wb.update_rd);
		end
		dbg_en = 1'b0;
	endtask

	task automatic run_alu(input logic [31:0] data, input logic [3:0] rd);
		wb_t exp_wb;
		update_rd = 1'b1;
		rd_sel = rd;
		wr_val = data;
		@(negedge clk);
		exp_wb = '{update_rd: 1'b1, rd_sel: rd, val: data};
		check_wb("wb", exp_wb, wb);
		check_bit("complete", 1'b0, complete);
		update_rd = 1'b0;
	endtask

	task automatic run_cache(input cache_op_e op, input logic [31:0] data,
			input logic [2:0] exp_strobes);
		int cycles;
		cache_instr = 1'b1;
		cache_op = op;
		wr_val = data;
		@(negedge clk);
		check_bit("i_inval", exp_strobes[2], i_inval);
		check_bit("d_inval", exp_strobes[1], d_inval);
		check_bit("d_flush", exp_strobes[0], d_flush);
		check_bit("complete", 1'b0, complete);
		if (op == cop_icache_inval) begin
			check_word("i_idx", 32'(data[ICACHE_IDX_BITS-1:0]), 32'(i_idx));
			i_cacheop_complete = 1'b1;
		end else begin
			check_word("d_idx", 32'(data[DCACHE_IDX_BITS-1:0]), 32'(d_idx));
			d_cacheop_complete = 1'b1;
		end
		wait_complete(cycles);
		check_bit("data_abort", 1'b0, data_abort);
		i_cacheop_complete = 1'b0;
		d_cacheop_complete = 1'b0;
		cache_instr = 1'b0;
		@(negedge clk);
		check_bit("complete", 1'b0, complete);
	endtask

	task automatic finish_test(input string name, input int line_no);
		if (test_errors == 0) begin
			pass_count++;
			$display("%0t line %0d %s ok", $time, line_no, name);
		end else begin
			fail_count++;
			$display("%0t line %0d %s FAILED with %0d errors", $time, line_no, name, test_errors);
		end
	endtask

	initial begin
		int          fd;
		int          n;
		int          line_no;
		int          width;
		int          abort_flag;
		string       line;
		string       op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp;
		logic [3:0]  rd;
		clk = 1'b0;
		rst = 1'b1;
		mem_req = '0;
		wr_val = '0;
		update_rd = 1'b0;
		rd_sel = '0;
		cache_instr = 1'b0;
		cache_op = cop_icache_inval;
		i_cacheop_complete = 1'b0;
		d_cacheop_complete = 1'b0;
		dbg_en = 1'b0;
		dbg_req = '0;
		pass_count = 0;
		fail_count = 0;
		repeat (10) @(negedge clk);
		rst = 1'b0;

		test_errors = 0;
		@(negedge clk);
		check_bit("wb.update_rd", 1'b0, wb.update_rd);
		check_bit("complete", 1'b0, complete);
		check_bit("data_abort", 1'b0, data_abort);
		check_bit("busy", 1'b0, busy);
		check_bit("i_inval", 1'b0, i_inval);
		check_bit("d_inval", 1'b0, d_inval);
		check_bit("d_flush", 1'b0, d_flush);
		finish_test("reset", 0);

		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0) begin
			$display("Could not open %s", PATTERN_FILE);
			fail_count++;
		end else begin
			line_no = 0;
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				line_no++;
				if (line.len() < 2 || line[0] == "#")
					continue;
				n = $sscanf(line, "%s %h %d %h %h %h %d",
					op, addr, width, data, rd, exp, abort_flag);
				if (n != 7) begin
					$display("Pattern line %0d could not be parsed", line_no);
					fail_count++;
					continue;
				end
				test_errors = 0;
				case (op)
					"load": run_access(0, 0, addr, mem_width_e'(width), data, rd, exp,
						abort_flag[0]);
					"store": run_access(0, 1, addr, mem_width_e'(width), data, rd, exp,
						abort_flag[0]);
					"dbg_read": run_access(1, 0, addr, mem_width_e'(width), data, rd, exp,
						abort_flag[0]);
					"dbg_write": run_access(1, 1, addr, mem_width_e'(width), data, rd, exp,
						abort_flag[0]);
					"alu": run_alu(data, rd);
					"cache": run_cache(cache_op_e'(width), data, exp[2:0]);
					default: begin
						$display("Unknown operation %s on pattern line %0d", op, line_no);
						test_errors++;
					end
				endcase
				finish_test(op, line_no);
			end
			$fclose(fd);
		end

		$display("%0d tests passed, %0d tests failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* hw/mem_stage.sv */
`timescale 1ns/1ns

module mem_stage (
	input  logic                                      clk,
	input  logic                                      rst,
	input  mem_stage_pkg::mem_req_t                   mem_req,
	input  logic [31:0]                               wr_val,
	input  logic                                      update_rd,
	input  logic [3:0]                                rd_sel,
	input  logic                                      cache_instr,
	input  mem_stage_pkg::cache_op_e                  cache_op,
	input  logic                                      i_cacheop_complete,
	input  logic                                      d_cacheop_complete,
	input  logic                                      dbg_en,
	input  mem_stage_pkg::dbg_req_t                   dbg_req,
	output mem_stage_pkg::wb_t                        wb,
	output logic                                      complete,
	output logic                                      data_abort,
	output logic                                      busy,
	output logic [31:0]                               dbg_rd_val,
	output logic                                      dbg_compl,
	output logic                                      i_inval,
	output logic                                      d_inval,
	output logic                                      d_flush,
	output logic [mem_stage_pkg::ICACHE_IDX_BITS-1:0] i_idx,
	output logic [mem_stage_pkg::DCACHE_IDX_BITS-1:0] d_idx
);
	import mem_stage_pkg::*;

	bus_req_t    bus_req;
	bus_rsp_t    bus_rsp;
	logic [31:0] load_data;
	logic        cache_done;

	mem_lane_align u_lane_align (
		.clk       (clk),
		.dbg_en    (dbg_en),
		.mem_req   (mem_req),
		.dbg_req   (dbg_req),
		.bus_rsp   (bus_rsp),
		.bus_req   (bus_req),
		.load_data (load_data)
	);

	mem_cache_maint u_cache_maint (
		.clk                (clk),
		.rst                (rst),
		.cache_instr        (cache_instr),
		.cache_op           (cache_op),
		.wr_val             (wr_val),
		.i_cacheop_complete (i_cacheop_complete),
		.d_cacheop_complete (d_cacheop_complete),
		.i_inval            (i_inval),
		.d_inval            (d_inval),
		.d_flush            (d_flush),
		.i_idx              (i_idx),
		.d_idx              (d_idx),
		.cache_done         (cache_done)
	);

	mem_writeback u_writeback (
		.clk        (clk),
		.rst        (rst),
		.dbg_en     (dbg_en),
		.mem_req    (mem_req),
		.update_rd  (update_rd),
		.rd_sel     (rd_sel),
		.wr_val     (wr_val),
		.bus_rsp    (bus_rsp),
		.load_data  (load_data),
		.cache_done (cache_done),
		.wb         (wb),
		.complete   (complete),
		.data_abort (data_abort),
		.busy       (busy),
		.dbg_compl  (dbg_compl),
		.dbg_rd_val (dbg_rd_val)
	);

	// Local data memory standing in for the external bus slave
	data_ram u_data_ram (
		.clk     (clk),
		.rst     (rst),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp)
	);

endmodule

/* hw/data_ram.sv */
`timescale 1ns/1ns

module data_ram (
	input  logic                    clk,
	input  logic                    rst,
	input  mem_stage_pkg::bus_req_t bus_req,
	output mem_stage_pkg::bus_rsp_t bus_rsp
);
	import mem_stage_pkg::*;

	localparam int WORDS = 2 ** RAM_ADDR_BITS;

	logic [31:0]              mem [WORDS];
	logic [RAM_ADDR_BITS-1:0] word_idx;
	logic                     in_range;
	logic                     accept;
	logic                     ack_q;
	logic                     error_q;
	logic [31:0]              rd_data_q;

	assign word_idx = bus_req.addr[RAM_ADDR_BITS-1:0];
	assign in_range = ~|bus_req.addr[29:RAM_ADDR_BITS];

	// A held request is answered once; the response cycle blocks a second sample
	assign accept = bus_req.access && !(ack_q || error_q);

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			error_q <= 1'b0;
		end else begin
			ack_q <= accept && in_range;
			error_q <= accept && !in_range;
		end
	end

	always_ff @(posedge clk) begin
		if (accept && in_range) begin
			rd_data_q <= mem[word_idx]; // Old contents on a write
			if (bus_req.wr_en) begin
				for (int b = 0; b < 4; b++) begin
					if (bus_req.bytesel[b])
						mem[word_idx][b*8 +: 8] <= bus_req.wr_val[b*8 +: 8];
				end
			end
		end
	end

	assign bus_rsp.rd_data = rd_data_q;
	assign bus_rsp.ack = ack_q;
	assign bus_rsp.error = error_q;

endmodule

/* hw/mem_writeback.sv */
`timescale 1ns/1ns

module mem_writeback (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    dbg_en,
	input  mem_stage_pkg::mem_req_t mem_req,
	input  logic                    update_rd,
	input  logic [3:0]              rd_sel,
	input  logic [31:0]             wr_val,
	input  mem_stage_pkg::bus_rsp_t bus_rsp,
	input  logic [31:0]             load_data,
	input  logic                    cache_done,
	output mem_stage_pkg::wb_t      wb,
	output logic                    complete,
	output logic                    data_abort,
	output logic                    busy,
	output logic                    dbg_compl,
	output logic [31:0]             dbg_rd_val
);
	import mem_stage_pkg::*;

	logic       mem_done;
	logic       loading;  // Outstanding pipeline access is a load
	logic [3:0] load_rd;  // Destination captured when the load was issued
	wb_t        load_wb;
	wb_t        alu_wb;

	assign mem_done = bus_rsp.ack | bus_rsp.error;

	assign complete = mem_done | cache_done;
	assign data_abort = bus_rsp.error;

	// Debug accesses complete in the same cycle as the bus response
	assign dbg_compl = dbg_en & mem_done;
	assign dbg_rd_val = load_data;

	always_ff @(posedge clk) begin
		alu_wb.rd_sel <= rd_sel;
		alu_wb.val <= wr_val;

		if (mem_req.load)
			load_rd <= mem_req.rd_sel;

		if (mem_done && loading) begin
			load_wb.rd_sel <= load_rd;
			load_wb.val <= load_data;
		end

		if (rst) begin
			loading <= 1'b0;
			load_wb.update_rd <= 1'b0;
			alu_wb.update_rd <= 1'b0;
		end else begin
			if (mem_done)
				loading <= 1'b0;
			else if (mem_req.load || mem_req.store)
				loading <= mem_req.load;

			// Faulting loads and loads under debug leave the register file alone
			load_wb.update_rd <= mem_done && loading && !bus_rsp.error && !dbg_en;
			alu_wb.update_rd <= update_rd;
		end
	end

	assign wb = load_wb.update_rd ? load_wb : alu_wb; // Load result wins the write port

	assign busy = mem_req.load | mem_req.store | wb.update_rd;

	// The RAM answers an access with either ack or error, never both
	ack_error_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(bus_rsp.ack && bus_rsp.error))
		else $error("ack and error in the same cycle");

endmodule

/* hw/mem_cache_maint.sv */
`timescale 1ns/1ns

module mem_cache_maint (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic                                        cache_instr,
	input  mem_stage_pkg::cache_op_e                    cache_op,
	input  logic [31:0]                                 wr_val,
	input  logic                                        i_cacheop_complete,
	input  logic                                        d_cacheop_complete,
	output logic                                        i_inval,
	output logic                                        d_inval,
	output logic                                        d_flush,
	output logic [mem_stage_pkg::ICACHE_IDX_BITS-1:0]   i_idx,
	output logic [mem_stage_pkg::DCACHE_IDX_BITS-1:0]   d_idx,
	output logic                                        cache_done
);
	import mem_stage_pkg::*;

	logic i_pending; // An instruction cache operation was issued and not yet completed
	logic d_pending;

	assign i_inval = cache_instr && cache_op == cop_icache_inval;
	assign d_inval = cache_instr && cache_op == cop_dcache_inval;
	assign d_flush = cache_instr && cache_op == cop_dcache_flush;

	// The set index rides in the low bits of the operand
	assign i_idx = wr_val[ICACHE_IDX_BITS-1:0];
	assign d_idx = wr_val[DCACHE_IDX_BITS-1:0];

	assign cache_done = i_cacheop_complete | d_cacheop_complete;

	always_ff @(posedge clk) begin
		if (rst) begin
			i_pending <= 1'b0;
			d_pending <= 1'b0;
		end else begin
			if (i_cacheop_complete)
				i_pending <= 1'b0;
			else if (i_inval)
				i_pending <= 1'b1;

			if (d_cacheop_complete)
				d_pending <= 1'b0;
			else if (d_inval || d_flush)
				d_pending <= 1'b1;
		end
	end

	// Each cache only completes operations that were sent to it
	i_done_expected: assert property (@(posedge clk) disable iff (rst)
		i_cacheop_complete |-> (i_pending || i_inval))
		else $error("icache completion without an operation");

	d_done_expected: assert property (@(posedge clk) disable iff (rst)
		d_cacheop_complete |-> (d_pending || d_inval || d_flush))
		else $error("dcache completion without an operation");

endmodule

/* hw/mem_lane_align.sv */
`timescale 1ns/1ns

module mem_lane_align (
	input  logic                    clk,
	input  logic                    dbg_en,
	input  mem_stage_pkg::mem_req_t mem_req,
	input  mem_stage_pkg::dbg_req_t dbg_req,
	input  mem_stage_pkg::bus_rsp_t bus_rsp,
	output mem_stage_pkg::bus_req_t bus_req,
	output logic [31:0]             load_data
);
	import mem_stage_pkg::*;

	logic [31:0] acc_addr;
	mem_width_e  acc_width;
	logic [31:0] acc_wr_data;
	logic [1:0]  lane;
	logic [31:0] rd_shifted;

	// The debugger owns the bus whenever debug mode is on
	always_comb begin
		if (dbg_en) begin
			acc_addr = dbg_req.addr;
			acc_width = dbg_req.width;
			acc_wr_data = dbg_req.wr_val;
			bus_req.access = dbg_req.access;
			bus_req.wr_en = dbg_req.wr_en;
		end else begin
			acc_addr = mem_req.addr;
			acc_width = mem_req.width;
			acc_wr_data = mem_req.mdr;
			bus_req.access = mem_req.load | mem_req.store;
			bus_req.wr_en = mem_req.store;
		end
	end

	assign lane = acc_addr[1:0];
	assign bus_req.addr = acc_addr[31:2];

	// Read data from the addressed lane moved down to bit 0
	assign rd_shifted = bus_rsp.rd_data >> {lane, 3'b000};

	always_comb begin
		case (acc_width)
			width_byte: begin
				bus_req.bytesel = 4'b0001 << lane;
				bus_req.wr_val = acc_wr_data << {lane, 3'b000};
				load_data = {24'b0, rd_shifted[7:0]};
			end
			width_half: begin
				// Only bit 1 picks the half, bit 0 is ignored
				bus_req.bytesel = lane[1] ? 4'b1100 : 4'b0011;
				bus_req.wr_val = lane[1] ? {acc_wr_data[15:0], 16'b0} : acc_wr_data;
				load_data = lane[1] ? {16'b0, bus_rsp.rd_data[31:16]}
				                    : {16'b0, bus_rsp.rd_data[15:0]};
			end
			default: begin
				bus_req.bytesel = 4'b1111;
				bus_req.wr_val = acc_wr_data;
				load_data = bus_rsp.rd_data;
			end
		endcase
	end

	// The execute stage issues one kind of access at a time
	load_store_exclusive: assert property (@(posedge clk) !(mem_req.load && mem_req.store))
		else $error("load and store presented together");

endmodule

/* hw/mem_stage_pkg.sv */
package mem_stage_pkg;

	// Cache set index widths, taken from the low bits of the ALU result
	localparam int ICACHE_IDX_BITS = 8;
	localparam int DCACHE_IDX_BITS = 8;

	// Word address bits decoded by the data RAM
	localparam int RAM_ADDR_BITS = 8;

	typedef enum logic [1:0] {
		width_byte = 2'd0,
		width_half = 2'd1,
		width_word = 2'd2
	} mem_width_e;

	typedef enum logic [1:0] {
		cop_icache_inval = 2'd0,
		cop_dcache_inval = 2'd1,
		cop_dcache_flush = 2'd2
	} cache_op_e;

	// Request from the execute stage, held until complete
	typedef struct packed {
		logic        load;
		logic        store;
		logic [31:0] addr;
		logic [31:0] mdr; // Store data before lane shifting
		mem_width_e  width;
		logic [3:0]  rd_sel;
	} mem_req_t;

	typedef struct packed {
		logic        access;
		logic        wr_en;
		logic [31:0] addr;
		mem_width_e  width;
		logic [31:0] wr_val;
	} dbg_req_t;

	typedef struct packed {
		logic [29:0] addr; // Word address
		logic [3:0]  bytesel;
		logic        wr_en;
		logic [31:0] wr_val;
		logic        access;
	} bus_req_t;

	typedef struct packed {
		logic [31:0] rd_data;
		logic        ack;
		logic        error;
	} bus_rsp_t;

	typedef struct packed {
		logic        update_rd;
		logic [3:0]  rd_sel;
		logic [31:0] val;
	} wb_t;

endpackage
